//--- hw/chunk_aligner.sv
`timescale 1ns/1ps
`include "istream_config.svh"

module chunk_aligner (
    istream_window_if.aligner                               win,
    output logic [`ISTREAM_WAYS-1:0]                        way_valid,
    output logic [`ISTREAM_WAYS-1:0]                        uncompressed,
    output istream_pkg::halfword_t [`ISTREAM_WAYS-1:0][1:0] way_instr,
    output istream_pkg::window_idx_t [`ISTREAM_WAYS-1:0]    lower_idx,
    output istream_pkg::window_mask_t                       ack_mask
);

    localparam int WIN = 2 * `ISTREAM_CHUNKS;

    // lowest set bit, zero when the vector is empty
    function automatic istream_pkg::window_idx_t lsb_index(
        input istream_pkg::window_mask_t vec
    );
        istream_pkg::window_idx_t idx;
        idx = '0;
        for (int i = WIN - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = istream_pkg::window_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // bits strictly above idx
    function automatic istream_pkg::window_mask_t above_mask(
        input istream_pkg::window_idx_t idx
    );
        istream_pkg::window_mask_t ones;
        ones = '1;
        return (ones << idx) << 1;
    endfunction

    // --------------------------------------------------
    // per-way chunk search
    // --------------------------------------------------

    always_comb begin
        istream_pkg::window_mask_t req;
        istream_pkg::window_mask_t up_req;
        istream_pkg::window_idx_t  lo;
        istream_pkg::window_idx_t  up;
        logic                      lo_present;
        logic                      uncomp;

        req      = win.window_valid;
        ack_mask = '0;
        for (int w = 0; w < `ISTREAM_WAYS; w++) begin
            lo_present = |req;
            lo         = lsb_index(req);
            up_req     = win.window_valid & above_mask(lo);
            up         = lsb_index(up_req);
            uncomp     = win.window_instr[lo][1:0] == 2'b11;

            uncompressed[w] = uncomp;
            lower_idx[w]    = lo;
            way_instr[w][0] = win.window_instr[lo];
            way_instr[w][1] = win.window_instr[up];

            if (lo_present && uncomp) begin
                // 32-bit instr needs its upper half in the window
                way_valid[w] = |up_req;
                if (|up_req) begin
                    ack_mask[lo] = 1'b1;
                    ack_mask[up] = 1'b1;
                end
                req = up_req & above_mask(up);
            end else if (lo_present) begin
                way_valid[w] = 1'b1;
                ack_mask[lo] = 1'b1;
                req          = up_req;
            end else begin
                way_valid[w] = 1'b0;
                req          = '0;
            end
        end
    end

    // acks must only cover chunks the store presented
    a_ack_in_window: assert final ((ack_mask & ~win.window_valid) == '0);

endmodule

//--- hw/dequeue_ctrl.sv
`timescale 1ns/1ps
`include "istream_config.svh"

module dequeue_ctrl (
    input  logic                                         CLK,
    input  logic                                         nRST,
    input  logic                                         restart,
    input  istream_pkg::pc_t                             restart_pc,
    input  logic                                         stall_sdeq,
    istream_window_if.ctrl                               win,
    input  istream_pkg::window_mask_t                    ack_mask,
    input  istream_pkg::window_idx_t [`ISTREAM_WAYS-1:0] lower_idx,
    output istream_pkg::pc_t [`ISTREAM_WAYS-1:0]         pc_sdeq,
    istream_deq_if.ctrl                                  deq
);

    localparam int CH = `ISTREAM_CHUNKS;
    localparam istream_pkg::pc_t INIT_PC = `ISTREAM_INIT_PC;

    istream_pkg::block_pc_t  block_pc;
    istream_pkg::block_pc_t  block_pc_next;
    istream_pkg::adv_count_t adv_raw;

    logic set0_done;
    logic set1_done;

    // --------------------------------------------------
    // set completion
    // --------------------------------------------------

    // done when every remaining valid chunk is acked now
    assign set0_done = win.set_present[0] &&
                       ((win.window_valid[CH-1:0] & ~ack_mask[CH-1:0]) == '0);
    assign set1_done = win.set_present[1] &&
                       ((win.window_valid[2*CH-1:CH] & ~ack_mask[2*CH-1:CH]) == '0);

    always_comb begin
        adv_raw       = '0;
        block_pc_next = block_pc;
        if (set0_done && set1_done) begin
            adv_raw       = 2'd2;
            block_pc_next = win.set1_after_pc;
        end else if (set0_done) begin
            adv_raw       = 2'd1;
            block_pc_next = win.set0_after_pc;
        end
    end

    assign deq.advance    = stall_sdeq ? '0 : adv_raw;
    assign deq.clear_mask = stall_sdeq ? '0 : ack_mask;

    // block PC of the deq0 set
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            block_pc <= INIT_PC[31:4];
        end else if (restart) begin
            block_pc <= restart_pc[31:4];
        end else if (!stall_sdeq) begin
            block_pc <= block_pc_next;
        end
    end

    // --------------------------------------------------
    // per-way PC
    // --------------------------------------------------

    // set1 block starts at set0's after_pc
    always_comb begin
        for (int w = 0; w < `ISTREAM_WAYS; w++) begin
            pc_sdeq[w] = {lower_idx[w][3] ? win.set0_after_pc : block_pc,
                          lower_idx[w][2:0], 1'b0};
        end
    end

    a_double_advance: assert property (
        @(posedge CLK) disable iff (!nRST)
        (deq.advance == 2'd2) |-> (set0_done && win.set_present[1])
    );

endmodule

//--- hw/istream_config.svh
`ifndef ISTREAM_CONFIG_SVH
`define ISTREAM_CONFIG_SVH

// --------------------------------------------------
// stream buffer geometry
// --------------------------------------------------

// number of stream sets in the ring
`define ISTREAM_SETS 8

// 16-bit chunks per fetch block
`define ISTREAM_CHUNKS 8

// instructions dequeued per cycle
`define ISTREAM_WAYS 4

// fetch PC out of reset
`define ISTREAM_INIT_PC 32'h80000000

`endif

//--- hw/istream_deq_if.sv
`timescale 1ns/1ps

interface istream_deq_if;

    // chunks consumed this cycle, window layout
    istream_pkg::window_mask_t clear_mask;

    // sets retired, both dequeue pointers move by this
    istream_pkg::adv_count_t   advance;

    modport ctrl (output clear_mask, advance);

    modport store (input clear_mask, advance);

endinterface

//--- hw/istream_pkg.sv
`include "istream_config.svh"

package istream_pkg;

    // --------------------------------------------------
    // datapath widths
    // --------------------------------------------------

    // one 16-bit instruction chunk
    typedef logic [15:0] halfword_t;

    // byte address
    typedef logic [31:0] pc_t;

    // 16-byte fetch block address, pc[31:4]
    typedef logic [27:0] block_pc_t;

    // per-chunk mask over one set
    typedef logic [`ISTREAM_CHUNKS-1:0] set_mask_t;

    // two-set dequeue window, set0 in the low half
    typedef logic [2*`ISTREAM_CHUNKS-1:0] window_mask_t;
    typedef logic [$clog2(2*`ISTREAM_CHUNKS)-1:0] window_idx_t;

    // ring index plus wrap bit
    typedef logic [$clog2(`ISTREAM_SETS):0] set_ptr_t;

    // sets retired per cycle, 0 to 2
    typedef logic [1:0] adv_count_t;

endpackage

//--- hw/istream_top.sv
`timescale 1ns/1ps
`include "istream_config.svh"

module istream_top (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  logic                                            restart,
    input  istream_pkg::pc_t                                restart_pc,
    // enqueue side
    input  logic                                            valid_senq,
    input  istream_pkg::set_mask_t                          chunk_valid_senq,
    input  istream_pkg::halfword_t [`ISTREAM_CHUNKS-1:0]    instr_senq,
    input  istream_pkg::pc_t                                after_pc_senq,
    output logic                                            stall_senq,
    // dequeue side
    output logic                                            valid_sdeq,
    output logic [`ISTREAM_WAYS-1:0]                        way_valid_sdeq,
    output logic [`ISTREAM_WAYS-1:0]                        uncompressed_sdeq,
    output istream_pkg::halfword_t [`ISTREAM_WAYS-1:0][1:0] instr_sdeq,
    output istream_pkg::pc_t [`ISTREAM_WAYS-1:0]            pc_sdeq,
    input  logic                                            stall_sdeq
);

    istream_window_if win_if ();
    istream_deq_if    deq_if ();

    istream_pkg::window_mask_t                    ack_mask;
    istream_pkg::window_idx_t [`ISTREAM_WAYS-1:0] lower_idx;

    stream_set_store u_store (
        .CLK              (CLK),
        .nRST             (nRST),
        .restart          (restart),
        .valid_senq       (valid_senq),
        .chunk_valid_senq (chunk_valid_senq),
        .instr_senq       (instr_senq),
        .after_pc_senq    (after_pc_senq),
        .stall_senq       (stall_senq),
        .win              (win_if.store),
        .deq              (deq_if.store)
    );

    chunk_aligner u_aligner (
        .win          (win_if.aligner),
        .way_valid    (way_valid_sdeq),
        .uncompressed (uncompressed_sdeq),
        .way_instr    (instr_sdeq),
        .lower_idx    (lower_idx),
        .ack_mask     (ack_mask)
    );

    dequeue_ctrl u_deq_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .restart    (restart),
        .restart_pc (restart_pc),
        .stall_sdeq (stall_sdeq),
        .win        (win_if.ctrl),
        .ack_mask   (ack_mask),
        .lower_idx  (lower_idx),
        .pc_sdeq    (pc_sdeq),
        .deq        (deq_if.ctrl)
    );

    // ways fill in order, so way 0 flags any output
    assign valid_sdeq = way_valid_sdeq[0];

endmodule

//--- hw/istream_window_if.sv
`timescale 1ns/1ps
`include "istream_config.svh"

interface istream_window_if;

    // valid bits and chunks of the deq0 and deq1 sets
    istream_pkg::window_mask_t                        window_valid;
    istream_pkg::halfword_t [2*`ISTREAM_CHUNKS-1:0]   window_instr;

    // next-block PCs stored with each window set
    istream_pkg::block_pc_t                           set0_after_pc;
    istream_pkg::block_pc_t                           set1_after_pc;

    // set occupies its window slot
    logic [1:0]                                       set_present;

    modport store (
        output window_valid, window_instr, set0_after_pc, set1_after_pc, set_present
    );

    modport aligner (input window_valid, window_instr);

    modport ctrl (input window_valid, set0_after_pc, set1_after_pc, set_present);

endinterface

//--- hw/stream_set_store.sv
`timescale 1ns/1ps
`include "istream_config.svh"

module stream_set_store (
    input  logic                                         CLK,
    input  logic                                         nRST,
    input  logic                                         restart,
    input  logic                                         valid_senq,
    input  istream_pkg::set_mask_t                       chunk_valid_senq,
    input  istream_pkg::halfword_t [`ISTREAM_CHUNKS-1:0] instr_senq,
    input  istream_pkg::pc_t                             after_pc_senq,
    output logic                                         stall_senq,
    istream_window_if.store                              win,
    istream_deq_if.store                                 deq
);

    localparam int CH    = `ISTREAM_CHUNKS;
    localparam int IDX_W = $clog2(`ISTREAM_SETS);

    // --------------------------------------------------
    // set ring storage
    // --------------------------------------------------

    istream_pkg::set_mask_t [`ISTREAM_SETS-1:0] set_valid;
    istream_pkg::set_mask_t [`ISTREAM_SETS-1:0] set_valid_next;
    istream_pkg::halfword_t [CH-1:0]            set_instr [`ISTREAM_SETS];
    istream_pkg::block_pc_t                     set_after_pc [`ISTREAM_SETS];

    istream_pkg::set_ptr_t enq_ptr;
    istream_pkg::set_ptr_t deq0_ptr;
    istream_pkg::set_ptr_t deq1_ptr;
    istream_pkg::set_ptr_t occupancy;

    logic [IDX_W-1:0] enq_idx;
    logic [IDX_W-1:0] deq0_idx;
    logic [IDX_W-1:0] deq1_idx;

    logic full;
    logic enq_fire;
    logic present0;
    logic present1;

    assign enq_idx  = enq_ptr[IDX_W-1:0];
    assign deq0_idx = deq0_ptr[IDX_W-1:0];
    assign deq1_idx = deq1_ptr[IDX_W-1:0];

    // wrap bit tells full from empty
    assign occupancy = enq_ptr - deq0_ptr;
    assign full      = (enq_idx == deq0_idx) && (enq_ptr[IDX_W] != deq0_ptr[IDX_W]);
    assign present0  = occupancy != '0;
    assign present1  = occupancy > istream_pkg::set_ptr_t'(1);

    assign stall_senq = full;
    assign enq_fire   = valid_senq && !full;

    // --------------------------------------------------
    // dequeue window
    // --------------------------------------------------

    assign win.window_valid  = {set_valid[deq1_idx] & {CH{present1}},
                                set_valid[deq0_idx] & {CH{present0}}};
    assign win.window_instr  = {set_instr[deq1_idx], set_instr[deq0_idx]};
    assign win.set0_after_pc = set_after_pc[deq0_idx];
    assign win.set1_after_pc = set_after_pc[deq1_idx];
    assign win.set_present   = {present1, present0};

    // clear acked chunks, then the enqueue write lands on its own free slot
    always_comb begin
        set_valid_next = set_valid;
        set_valid_next[deq0_idx] = set_valid_next[deq0_idx] & ~deq.clear_mask[CH-1:0];
        set_valid_next[deq1_idx] = set_valid_next[deq1_idx] & ~deq.clear_mask[2*CH-1:CH];
        if (enq_fire) begin
            set_valid_next[enq_idx] = chunk_valid_senq;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            set_valid <= '0;
            enq_ptr   <= '0;
            deq0_ptr  <= '0;
            deq1_ptr  <= istream_pkg::set_ptr_t'(1);
        end else if (restart) begin
            set_valid <= '0;
            enq_ptr   <= '0;
            deq0_ptr  <= '0;
            deq1_ptr  <= istream_pkg::set_ptr_t'(1);
        end else begin
            set_valid <= set_valid_next;
            deq0_ptr  <= deq0_ptr + istream_pkg::set_ptr_t'(deq.advance);
            deq1_ptr  <= deq1_ptr + istream_pkg::set_ptr_t'(deq.advance);
            if (enq_fire) begin
                enq_ptr <= enq_ptr + istream_pkg::set_ptr_t'(1);
            end
        end
    end

    // payload only, valid bits gate it
    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            set_instr[enq_idx]    <= instr_senq;
            set_after_pc[enq_idx] <= after_pc_senq[31:4];
        end
    end

    // retiring more sets than held would wrap the ring
    a_occupancy_bound: assert property (
        @(posedge CLK) disable iff (!nRST)
        occupancy <= istream_pkg::set_ptr_t'(`ISTREAM_SETS)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module istream_tb -f verilog.f || exit 1
out=$(./obj_dir/Vistream_tb) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1

//--- sim/istream_tb.sv
`timescale 1ns/1ps
`include "istream_config.svh"

module istream_tb;

    localparam int PERIOD         = 20;
    localparam int CH             = `ISTREAM_CHUNKS;
    localparam int WAYS           = `ISTREAM_WAYS;
    localparam int IDXW           = $clog2(`ISTREAM_CHUNKS);
    localparam int NUM_ROWS       = 5;
    localparam int CYCLES_PER_ROW = 200;
    localparam int WATCHDOG_NS    = (NUM_ROWS * CYCLES_PER_ROW + 20) * PERIOD;

    typedef struct packed {
        logic [CH-1:0]       mask;
        logic [CH-1:0][15:0] hw;
        logic [31:0]         after;
    } block_t;

    typedef struct packed {
        int          first;
        int          num;
        int          mode;
        int          gap;
        logic        rst;
        logic [31:0] rpc;
        int          exp;
    } row_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [15:0] lo;
        logic [15:0] hi;
        logic        unc;
        int          need;
    } entry_t;

    logic                                            CLK;
    logic                                            nRST;
    logic                                            restart;
    istream_pkg::pc_t                                restart_pc;
    logic                                            valid_senq;
    istream_pkg::set_mask_t                          chunk_valid_senq;
    istream_pkg::halfword_t [CH-1:0]                 instr_senq;
    istream_pkg::pc_t                                after_pc_senq;
    logic                                            stall_senq;
    logic                                            valid_sdeq;
    logic [WAYS-1:0]                                 way_valid_sdeq;
    logic [WAYS-1:0]                                 uncompressed_sdeq;
    istream_pkg::halfword_t [WAYS-1:0][1:0]          instr_sdeq;
    istream_pkg::pc_t [WAYS-1:0]                     pc_sdeq;
    logic                                            stall_sdeq;

    block_t blocks[$];
    row_t   rows[$];
    string  row_names[$];
    entry_t expq[$];
    int     errors;
    int     accepted;
    int     consumed;
    int     rows_ok;
    int     rows_bad;

    istream_top dut (
        .CLK               (CLK),
        .nRST              (nRST),
        .restart           (restart),
        .restart_pc        (restart_pc),
        .valid_senq        (valid_senq),
        .chunk_valid_senq  (chunk_valid_senq),
        .instr_senq        (instr_senq),
        .after_pc_senq     (after_pc_senq),
        .stall_senq        (stall_senq),
        .valid_sdeq        (valid_sdeq),
        .way_valid_sdeq    (way_valid_sdeq),
        .uncompressed_sdeq (uncompressed_sdeq),
        .instr_sdeq        (instr_sdeq),
        .pc_sdeq           (pc_sdeq),
        .stall_sdeq        (stall_sdeq)
    );

    initial CLK = 1'b0;
    always #(PERIOD / 2) CLK = ~CLK;

    // --------------------------------------------------
    // test table
    // --------------------------------------------------

    // compressed chunks, low bits 01
    function automatic logic [CH-1:0][15:0] seq_chunks(input logic [15:0] base);
        logic [CH-1:0][15:0] hw;
        for (int c = 0; c < CH; c++) begin
            hw[c] = base + 16'(c << 4);
        end
        return hw;
    endfunction

    task automatic add_block(input logic [CH-1:0] mask, input logic [CH-1:0][15:0] hw,
                             input logic [31:0] after);
        blocks.push_back('{mask: mask, hw: hw, after: after});
    endtask

    task automatic add_row(input string name, input int num, input int mode, input int gap,
                           input logic rst, input logic [31:0] rpc, input int exp);
        row_names.push_back(name);
        rows.push_back('{first: blocks.size() - num, num: num, mode: mode, gap: gap,
                         rst: rst, rpc: rpc, exp: exp});
    endtask

    // stall mode 0 none, 1 random, 2 held until the ring fills then random
    task automatic build_table();
        logic [CH-1:0][15:0] hw;
        add_block(8'hff, seq_chunks(16'h1001), 32'h80000010);
        add_row("compressed_block", 1, 0, 0, 1'b0, 32'h0, 8);

        hw    = seq_chunks(16'h2001);
        hw[7] = 16'h2f73;
        add_block(8'hff, hw, 32'h80000010);
        hw    = seq_chunks(16'h3001);
        hw[0] = 16'h3abc;
        add_block(8'hff, hw, 32'h80000020);
        add_row("cross_block_uncomp", 2, 0, 12, 1'b0, 32'h0, 15);

        // masked chunk 3 looks uncompressed but must be skipped
        hw    = seq_chunks(16'h4001);
        hw[1] = 16'h4013;
        hw[3] = 16'h40f3;
        hw[7] = 16'h4f7b;
        add_block(8'b1010_0110, hw, 32'h80000100);
        add_block(8'b0111_0001, seq_chunks(16'h5001), 32'h80000110);
        add_row("masked_gaps", 2, 1, 0, 1'b0, 32'h0, 6);

        for (int b = 0; b < 9; b++) begin
            add_block(8'hff, seq_chunks(16'h6001 + 16'(b * 256)), 32'h80000010 + 32'(b * 16));
        end
        add_row("ring_full", 9, 2, 0, 1'b0, 32'h0, 72);

        hw    = seq_chunks(16'h7001);
        hw[2] = 16'h7023;
        add_block(8'hff, hw, 32'h40000030);
        add_block(8'h0f, seq_chunks(16'h7101), 32'h40000040);
        add_row("restart_mid_stream", 2, 1, 0, 1'b1, 32'h40000020, 11);
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------

    // flatten valid chunks in program order, then pair uncompressed halves
    task automatic build_expected(input row_t r);
        entry_t           e;
        logic [31:0]      cpc[$];
        logic [15:0]      chw[$];
        int               cblk[$];
        logic [31:0]      base;
        int               i;
        expq.delete();
        base = r.rst ? r.rpc : `ISTREAM_INIT_PC;
        for (int b = r.first; b < r.first + r.num; b++) begin
            for (int c = 0; c < CH; c++) begin
                if (blocks[b].mask[c]) begin
                    cpc.push_back({base[31:4], IDXW'(c), 1'b0});
                    chw.push_back(blocks[b].hw[c]);
                    cblk.push_back(b - r.first);
                end
            end
            base = blocks[b].after;
        end
        i = 0;
        while (i < chw.size()) begin
            e.pc   = cpc[i];
            e.lo   = chw[i];
            e.hi   = '0;
            e.unc  = chw[i][1:0] == 2'b11;
            e.need = cblk[i];
            if (e.unc) begin
                // upper half never arrives
                if (i + 1 >= chw.size()) break;
                e.hi   = chw[i + 1];
                e.need = cblk[i + 1];
                i      = i + 2;
            end else begin
                i = i + 1;
            end
            expq.push_back(e);
        end
    endtask

    // --------------------------------------------------
    // checks
    // --------------------------------------------------

    task automatic report_value(input string sig, input int w, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("[FAIL] %s[%0d] = %h, expected %h", sig, w, got, exp);
        errors++;
    endtask

    // ways are consumed at the next edge when stall_sdeq is low
    task automatic check_outputs();
        entry_t e;
        if (!valid_sdeq || stall_sdeq) return;
        for (int w = 0; w < WAYS; w++) begin
            if (way_valid_sdeq[w]) begin
                assert (expq.size() > 0) else begin
                    $display("extra instruction on way %0d at pc %h", w, pc_sdeq[w]);
                    errors++;
                end
                if (expq.size() > 0) begin
                    e = expq.pop_front();
                    consumed++;
                    assert (pc_sdeq[w] == e.pc)
                        else report_value("pc_sdeq", w, pc_sdeq[w], e.pc);
                    assert (instr_sdeq[w][0] == e.lo)
                        else report_value("instr_sdeq_lo", w, 32'(instr_sdeq[w][0]), 32'(e.lo));
                    assert (uncompressed_sdeq[w] == e.unc)
                        else report_value("uncompressed_sdeq", w, 32'(uncompressed_sdeq[w]),
                                          32'(e.unc));
                    if (e.unc) begin
                        assert (instr_sdeq[w][1] == e.hi)
                            else report_value("instr_sdeq_hi", w, 32'(instr_sdeq[w][1]),
                                              32'(e.hi));
                    end
                    assert (e.need < accepted) else begin
                        $display("way %0d came out before its upper half was enqueued", w);
                        errors++;
                    end
                end
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge CLK);
        nRST       = 1'b0;
        restart    = 1'b0;
        valid_senq = 1'b0;
        stall_sdeq = 1'b0;
        repeat (8) @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        assert (!valid_sdeq && !stall_senq) else begin
            $display("dequeue or enqueue side not idle after reset");
            errors++;
        end
    endtask

    // two junk blocks held under stall, then restart
    task automatic enter_restart(input logic [31:0] rpc);
        stall_sdeq = 1'b1;
        for (int b = 0; b < 2; b++) begin
            @(negedge CLK);
            valid_senq       = 1'b1;
            chunk_valid_senq = '1;
            instr_senq       = {CH{16'h0f0d}};
            after_pc_senq    = 32'h80000010 + 32'(b * 16);
        end
        @(negedge CLK);
        valid_senq = 1'b0;
        assert (valid_sdeq) else begin
            $display("junk stream never reached the dequeue outputs");
            errors++;
        end
        restart    = 1'b1;
        restart_pc = rpc;
        @(negedge CLK);
        restart = 1'b0;
        assert (!valid_sdeq && !stall_senq) else begin
            $display("restart left data in the buffer");
            errors++;
        end
    endtask

    task automatic run_row(input int n);
        row_t r;
        int   start_err;
        int   idle;
        logic full_checked;
        r            = rows[n];
        start_err    = errors;
        accepted     = 0;
        consumed     = 0;
        idle         = 0;
        full_checked = 1'b0;
        apply_reset();
        if (r.rst) begin
            enter_restart(r.rpc);
        end
        build_expected(r);
        while (accepted < r.num || consumed < r.exp) begin
            @(negedge CLK);
            stall_sdeq = (r.mode == 2 && accepted < `ISTREAM_SETS) ||
                         (r.mode != 0 && $urandom_range(0, 1) == 1);
            check_outputs();
            if (r.mode == 2 && accepted == `ISTREAM_SETS && !full_checked) begin
                full_checked = 1'b1;
                assert (stall_senq) else begin
                    $display("ring holds every set but stall_senq is low");
                    errors++;
                end
            end
            if (accepted < r.num && idle == 0) begin
                valid_senq       = 1'b1;
                chunk_valid_senq = blocks[r.first + accepted].mask;
                instr_senq       = blocks[r.first + accepted].hw;
                after_pc_senq    = blocks[r.first + accepted].after;
                if (!stall_senq) begin
                    accepted++;
                    idle = r.gap;
                end
            end else begin
                valid_senq = 1'b0;
                if (idle > 0) idle--;
            end
        end
        // drain, anything left is an extra
        repeat (3) begin
            @(negedge CLK);
            valid_senq = 1'b0;
            stall_sdeq = 1'b0;
            check_outputs();
        end
        assert (expq.size() == 0) else begin
            $display("%0d expected instructions never came out", expq.size());
            errors++;
        end
        assert (consumed == r.exp) else begin
            $display("%0d instructions came out but the table lists %0d", consumed, r.exp);
            errors++;
        end
        if (errors == start_err) rows_ok++;
        else rows_bad++;
        $display("%-20s %s  %0d instructions", row_names[n],
                 (errors == start_err) ? "ok" : "bad", consumed);
    endtask

    // --------------------------------------------------
    // main sequence and watchdog
    // --------------------------------------------------

    initial begin
        nRST             = 1'b0;
        restart          = 1'b0;
        restart_pc       = '0;
        valid_senq       = 1'b0;
        chunk_valid_senq = '0;
        instr_senq       = '0;
        after_pc_senq    = '0;
        stall_sdeq       = 1'b0;
        errors           = 0;
        rows_ok          = 0;
        rows_bad         = 0;
        void'($urandom(90));
        build_table();
        for (int n = 0; n < rows.size(); n++) begin
            run_row(n);
        end
        $display("rows ok %0d, rows bad %0d, errors %0d", rows_ok, rows_bad, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, a test stopped making progress");
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hw
hw/istream_pkg.sv
hw/istream_window_if.sv
hw/istream_deq_if.sv
hw/stream_set_store.sv
hw/chunk_aligner.sv
hw/dequeue_ctrl.sv
hw/istream_top.sv
sim/istream_tb.sv
